//--- design/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

   // defaults for the byte producer / word consumer pairing
   localparam int DEF_W_DATA_W = 8;
   localparam int DEF_R_DATA_W = 32;
   // counted in write-width units
   localparam int DEF_ADDR_W   = 6;

   function automatic int fifo_max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int fifo_min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of wide/narrow ratio, 0 when both widths match
   function automatic int fifo_ratio_log2(input int a, input int b);
      return $clog2(fifo_max_w(a, b) / fifo_min_w(a, b));
   endfunction

endpackage

//--- design/fifo_status_pkg.sv
package fifo_status_pkg;

   // level field holds 0..depth, so one bit over the address width
   localparam int LEVEL_W = fifo_cfg_pkg::DEF_ADDR_W + 1;

   // threshold configuration, held steady by the driver
   typedef struct packed {
      logic [LEVEL_W-1:0] almost_full_lvl;
      logic [LEVEL_W-1:0] almost_empty_lvl;
   } fifo_thresh_t;

   // status word presented at the top level
   typedef struct packed {
      logic               empty;
      logic               full;
      logic               almost_empty;
      logic               almost_full;
      // sticky until clr_flags
      logic               overflow;
      logic               underflow;
      logic [LEVEL_W-1:0] level;
   } fifo_status_t;

endpackage

//--- design/iob_ram_2p_asym.sv
`timescale 1ns/1ps

module iob_ram_2p_asym
   import fifo_cfg_pkg::*;
#(
   parameter int  W_DATA_W   = DEF_W_DATA_W,
   parameter int  R_DATA_W   = DEF_R_DATA_W,
   // address width in narrow units
   parameter int  ADDR_W     = DEF_ADDR_W,
   localparam int MAX_W      = fifo_max_w(W_DATA_W, R_DATA_W),
   localparam int MIN_W      = fifo_min_w(W_DATA_W, R_DATA_W),
   localparam int RATIO_LOG2 = fifo_ratio_log2(W_DATA_W, R_DATA_W),
   localparam int MINADDR_W  = ADDR_W - RATIO_LOG2,
   localparam int W_ADDR_W   = (W_DATA_W == MAX_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W   = (R_DATA_W == MAX_W) ? MINADDR_W : ADDR_W
) (
   input  logic                clk,

   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,

   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   localparam int RATIO = 1 << RATIO_LOG2;
   localparam int DEPTH = 1 << MINADDR_W;

   // one narrow bank per lane of the wide word
   logic [MIN_W-1:0] mem [RATIO][DEPTH];

   logic [RATIO-1:0]            bank_we;
   logic [MINADDR_W-1:0]        w_row;
   logic [RATIO-1:0][MIN_W-1:0] w_slice;

   logic [R_DATA_W-1:0]         rd_word;
   logic [R_DATA_W-1:0]         rd_q = '0;

   // write side mapping onto the banks
   if (W_DATA_W >= R_DATA_W) begin : g_wr_wide
      // wide word spreads over all banks, lane 0 in the low bits
      assign bank_we = '1;
      assign w_row   = w_addr;
      assign w_slice = w_data;
   end else begin : g_wr_narrow
      // low address bits pick the lane
      assign bank_we = RATIO'(1) << w_addr[RATIO_LOG2-1:0];
      assign w_row   = w_addr[ADDR_W-1:RATIO_LOG2];
      assign w_slice = {RATIO{w_data}};
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < RATIO; b++) begin
         if (w_en && bank_we[b]) begin
            mem[b][w_row] <= w_slice[b];
         end
      end
   end

   // read side mapping
   if (R_DATA_W >= W_DATA_W) begin : g_rd_wide
      for (genvar b = 0; b < RATIO; b++) begin : g_rd_bank
         assign rd_word[b*MIN_W +: MIN_W] = mem[b][r_addr];
      end
   end else begin : g_rd_narrow
      assign rd_word = mem[r_addr[RATIO_LOG2-1:0]][r_addr[ADDR_W-1:RATIO_LOG2]];
   end

   // read register, holds between accepted reads
   always_ff @(posedge clk) begin
      if (r_en) begin
         rd_q <= rd_word;
      end
   end

   assign r_data = rd_q;

endmodule

//--- design/iob_fifo_sync.sv
`timescale 1ns/1ps

module iob_fifo_sync
   import fifo_cfg_pkg::*;
#(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   // in write-width units when writes are narrow
   parameter int ADDR_W   = DEF_ADDR_W
) (
   input  logic                clk,
   input  logic                rst_n,

   // read port
   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,
   output logic                r_empty,

   // write port
   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,
   output logic                w_full,

   // occupancy in narrow units
   output logic [ADDR_W:0]     level,

   // requests dropped because of full or empty
   output logic                w_refused,
   output logic                r_refused
);

   localparam int MAX_W      = fifo_max_w(W_DATA_W, R_DATA_W);
   localparam int RATIO_LOG2 = fifo_ratio_log2(W_DATA_W, R_DATA_W);
   localparam int MINADDR_W  = ADDR_W - RATIO_LOG2;
   localparam int W_ADDR_W   = (W_DATA_W == MAX_W) ? MINADDR_W : ADDR_W;
   localparam int R_ADDR_W   = (R_DATA_W == MAX_W) ? MINADDR_W : ADDR_W;

   // per-operation level step, the wide side moves by the ratio
   localparam logic [ADDR_W:0] W_INCR =
      (W_DATA_W > R_DATA_W) ? (ADDR_W+1)'(1 << RATIO_LOG2) : (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] R_INCR =
      (R_DATA_W > W_DATA_W) ? (ADDR_W+1)'(1 << RATIO_LOG2) : (ADDR_W+1)'(1);
   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(1) << ADDR_W;

   logic                w_en_int;
   logic                r_en_int;
   logic [W_ADDR_W-1:0] w_addr;
   logic [R_ADDR_W-1:0] r_addr;
   logic [ADDR_W:0]     w_step;
   logic [ADDR_W:0]     r_step;

   // effective enables
   assign w_en_int  = w_en & ~w_full;
   assign r_en_int  = r_en & ~r_empty;

   assign w_refused = w_en & w_full;
   assign r_refused = r_en & r_empty;

   // address counters wrap at their own width
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         w_addr <= '0;
      end else if (w_en_int) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_addr <= '0;
      end else if (r_en_int) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // net level change, modulo arithmetic handles the subtract
   assign w_step = w_en_int ? W_INCR : '0;
   assign r_step = r_en_int ? R_INCR : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level <= '0;
      end else begin
         level <= level + w_step - r_step;
      end
   end

   // not enough data for one read word
   assign r_empty = level < R_INCR;

   // no room for one more write word
   assign w_full  = level > (FIFO_SIZE - W_INCR);

   iob_ram_2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_ram (
      .clk    (clk),
      .w_en   (w_en_int),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (r_en_int),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

//--- design/fifo_level_monitor.sv
`timescale 1ns/1ps

module fifo_level_monitor
   import fifo_cfg_pkg::*;
   import fifo_status_pkg::*;
#(
   parameter int ADDR_W = DEF_ADDR_W
) (
   input  logic            clk,
   input  logic            rst_n,

   input  logic [ADDR_W:0] level,
   input  logic            w_refused,
   input  logic            r_refused,
   input  logic            clr_flags,
   input  fifo_thresh_t    thresh,

   output logic            almost_full,
   output logic            almost_empty,
   output logic            overflow,
   output logic            underflow
);

   // threshold flags lag the level by one cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         almost_full  <= 1'b0;
         almost_empty <= 1'b0;
      end else begin
         almost_full  <= level >= thresh.almost_full_lvl;
         almost_empty <= level <= thresh.almost_empty_lvl;
      end
   end

   // sticky overflow, a new event beats a clear in the same cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         overflow <= 1'b0;
      end else if (w_refused) begin
         overflow <= 1'b1;
      end else if (clr_flags) begin
         overflow <= 1'b0;
      end
   end

   // sticky underflow, same priority
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         underflow <= 1'b0;
      end else if (r_refused) begin
         underflow <= 1'b1;
      end else if (clr_flags) begin
         underflow <= 1'b0;
      end
   end

endmodule

//--- design/fifo_sync_top.sv
`timescale 1ns/1ps

module fifo_sync_top
   import fifo_cfg_pkg::*;
   import fifo_status_pkg::*;
#(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   parameter int ADDR_W   = DEF_ADDR_W
) (
   input  logic                clk,
   input  logic                rst_n,

   input  logic                w_en,
   input  logic [W_DATA_W-1:0] w_data,

   input  logic                r_en,
   output logic [R_DATA_W-1:0] r_data,

   input  fifo_thresh_t        thresh,
   input  logic                clr_flags,

   output fifo_status_t        status
);

   logic            fifo_empty;
   logic            fifo_full;
   logic [ADDR_W:0] fifo_level;
   logic            w_refused;
   logic            r_refused;
   logic            almost_full;
   logic            almost_empty;
   logic            overflow;
   logic            underflow;

   iob_fifo_sync #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .r_en      (r_en),
      .r_data    (r_data),
      .r_empty   (fifo_empty),
      .w_en      (w_en),
      .w_data    (w_data),
      .w_full    (fifo_full),
      .level     (fifo_level),
      .w_refused (w_refused),
      .r_refused (r_refused)
   );

   fifo_level_monitor #(
      .ADDR_W (ADDR_W)
   ) u_monitor (
      .clk          (clk),
      .rst_n        (rst_n),
      .level        (fifo_level),
      .w_refused    (w_refused),
      .r_refused    (r_refused),
      .clr_flags    (clr_flags),
      .thresh       (thresh),
      .almost_full  (almost_full),
      .almost_empty (almost_empty),
      .overflow     (overflow),
      .underflow    (underflow)
   );

   // empty and full are live, the rest comes from the monitor
   assign status = '{
      empty:        fifo_empty,
      full:         fifo_full,
      almost_empty: almost_empty,
      almost_full:  almost_full,
      overflow:     overflow,
      underflow:    underflow,
      level:        LEVEL_W'(fifo_level)
   };

endmodule

//--- dv/fifo_sync_properties.sv
`timescale 1ns/1ps

module fifo_sync_properties
   import fifo_cfg_pkg::*;
#(
   parameter int ADDR_W   = DEF_ADDR_W,
   parameter int R_ADDR_W = DEF_ADDR_W
) (
   input logic                clk,
   input logic                rst_n,
   input logic                r_empty,
   input logic                w_full,
   // read address counter, advances once per accepted read
   input logic [R_ADDR_W-1:0] r_addr,
   input logic [ADDR_W:0]     level
);

   localparam logic [ADDR_W:0] DEPTH = (ADDR_W+1)'(1) << ADDR_W;

   full_empty_exclusive: assert property (
      @(posedge clk) disable iff (!rst_n) !(w_full && r_empty)
   ) else $error("full and empty are both high");

   level_in_range: assert property (
      @(posedge clk) disable iff (!rst_n) level <= DEPTH
   ) else $error("level %0d is above the depth", level);

   // the read pointer must not move across an edge taken while empty
   no_read_when_empty: assert property (
      @(posedge clk) disable iff (!rst_n) r_empty |=> $stable(r_addr)
   ) else $error("read accepted while empty");

endmodule

bind iob_fifo_sync fifo_sync_properties #(
   .ADDR_W   (ADDR_W),
   .R_ADDR_W (R_ADDR_W)
) u_properties (
   .clk      (clk),
   .rst_n    (rst_n),
   .r_empty  (r_empty),
   .w_full   (w_full),
   .r_addr   (r_addr),
   .level    (level)
);

//--- dv/fifo_sync_tb.sv
`timescale 1ns/1ps

module fifo_sync_tb
   import fifo_cfg_pkg::*;
   import fifo_status_pkg::*;
();

   localparam int W_DATA_W = DEF_W_DATA_W;
   localparam int R_DATA_W = DEF_R_DATA_W;
   localparam int ADDR_W   = DEF_ADDR_W;
   // storage in bytes, and bytes per read word
   localparam int DEPTH    = 1 << ADDR_W;
   localparam int R_BYTES  = R_DATA_W / W_DATA_W;

   typedef struct {
      string name;
      int    n_wr;
      int    n_rd;
      bit    overlap;
      bit    clr;
      int    af_lvl;
      int    ae_lvl;
      int    exp_level;
   } row_t;

   logic                clk = 1'b0;
   logic                rst_n;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                r_en;
   logic [R_DATA_W-1:0] r_data;
   fifo_thresh_t        thresh;
   logic                clr_flags;
   fifo_status_t        status;

   row_t                rows[$];
   string               cur_name = "reset";
   int                  data_errs = 0;
   int                  status_errs = 0;
   int                  level_errs = 0;
   int                  cycle_cnt = 0;
   int                  cycle_limit = 0;

   // reference model state
   logic [W_DATA_W-1:0] model_q[$];
   logic [R_DATA_W-1:0] exp_rdata = '0;
   bit                  m_af = 1'b0;
   bit                  m_ae = 1'b0;
   bit                  m_ovf = 1'b0;
   bit                  m_unf = 1'b0;

   always #50 clk = ~clk;

   fifo_sync_top #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) u_fifo_sync_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .w_en      (w_en),
      .w_data    (w_data),
      .r_en      (r_en),
      .r_data    (r_data),
      .thresh    (thresh),
      .clr_flags (clr_flags),
      .status    (status)
   );

   // watchdog
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic add_row(input string name, input int n_wr, input int n_rd,
                          input bit overlap, input bit clr, input int af_lvl,
                          input int ae_lvl, input int exp_level);
      row_t r;
      r.name      = name;
      r.n_wr      = n_wr;
      r.n_rd      = n_rd;
      r.overlap   = overlap;
      r.clr       = clr;
      r.af_lvl    = af_lvl;
      r.ae_lvl    = ae_lvl;
      r.exp_level = exp_level;
      rows.push_back(r);
   endtask

   function automatic fifo_status_t model_status();
      fifo_status_t s;
      int lvl;
      lvl            = model_q.size();
      s.empty        = lvl < R_BYTES;
      s.full         = lvl > DEPTH - 1;
      s.almost_empty = m_ae;
      s.almost_full  = m_af;
      s.overflow     = m_ovf;
      s.underflow    = m_unf;
      s.level        = LEVEL_W'(lvl);
      return s;
   endfunction

   task automatic check_data(input logic [R_DATA_W-1:0] exp, input logic [R_DATA_W-1:0] act);
      if (act !== exp) begin
         data_errs++;
         $display("Error: %s r_data expected %h, actual %h", cur_name, exp, act);
      end
   endtask

   task automatic check_status(input fifo_status_t exp, input fifo_status_t act);
      if (act !== exp) begin
         status_errs++;
         $display("Error: %s status expected %p, actual %p", cur_name, exp, act);
      end
   endtask

   task automatic check_level(input logic [LEVEL_W-1:0] exp, input logic [LEVEL_W-1:0] act);
      if (act !== exp) begin
         level_errs++;
         $display("Error: %s end level expected %0d, actual %0d", cur_name, exp, act);
      end
   endtask

   // drive one cycle at the falling edge, predict the next rising edge, check
   task automatic drive_cycle(input bit we, input bit re, input bit clr);
      int                  lvl;
      bit                  was_full;
      bit                  was_empty;
      logic [W_DATA_W-1:0] wbyte;
      logic [R_DATA_W-1:0] word;
      wbyte     = W_DATA_W'($urandom);
      w_en      = we;
      w_data    = wbyte;
      r_en      = re;
      clr_flags = clr;
      lvl       = model_q.size();
      was_full  = lvl > DEPTH - 1;
      was_empty = lvl < R_BYTES;
      // almost flags see the level before this edge
      m_af = lvl >= int'(thresh.almost_full_lvl);
      m_ae = lvl <= int'(thresh.almost_empty_lvl);
      if (we && was_full) begin
         m_ovf = 1'b1;
      end else if (clr) begin
         m_ovf = 1'b0;
      end
      if (re && was_empty) begin
         m_unf = 1'b1;
      end else if (clr) begin
         m_unf = 1'b0;
      end
      if (re && !was_empty) begin
         // first byte in lands in the low lane
         for (int i = 0; i < R_BYTES; i++) begin
            word[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();
         end
         exp_rdata = word;
      end
      if (we && !was_full) begin
         model_q.push_back(wbyte);
      end
      @(negedge clk);
      check_status(model_status(), status);
      check_data(exp_rdata, r_data);
   endtask

   initial begin
      int n_cycles;
      void'($urandom(32'hebe4_c9a6));
      rst_n                   = 1'b0;
      w_en                    = 1'b0;
      w_data                  = '0;
      r_en                    = 1'b0;
      clr_flags               = 1'b0;
      thresh.almost_full_lvl  = LEVEL_W'(48);
      thresh.almost_empty_lvl = LEVEL_W'(8);

      //      name            wr  rd ovl clr  af  ae  end level
      add_row("reset_idle",    0,  0, 0, 0, 48,  8,  0);
      add_row("pack_12",      12,  3, 0, 0, 48,  8,  0);
      add_row("fill_64",      65,  0, 0, 0, 48,  8, 64);
      add_row("drain_64",      0, 16, 0, 0, 48,  8,  0);
      add_row("underflow",     0,  2, 0, 0, 48,  8,  0);
      add_row("clear_flags",   0,  0, 0, 1, 48,  8,  0);
      add_row("thresh_fill",  40,  0, 0, 0, int'($urandom_range(60, 20)),
              int'($urandom_range(30, 2)), 40);
      add_row("thresh_drain",  0, 10, 0, 0, int'($urandom_range(60, 20)),
              int'($urandom_range(30, 2)),  0);
      add_row("prefill",      32,  0, 0, 0, 48,  8, 32);
      add_row("mixed",        48,  8, 1, 0, 48,  8, 48);
      add_row("drain_mixed",   0, 12, 0, 0, 48,  8,  0);

      // each row adds a clear cycle and two idle cycles
      cycle_limit = 50;
      foreach (rows[i]) begin
         if (rows[i].overlap) begin
            cycle_limit += ((rows[i].n_wr > rows[i].n_rd) ? rows[i].n_wr : rows[i].n_rd) + 3;
         end else begin
            cycle_limit += rows[i].n_wr + rows[i].n_rd + 3;
         end
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_status(model_status(), status);
      check_data(exp_rdata, r_data);

      foreach (rows[i]) begin
         cur_name                = rows[i].name;
         thresh.almost_full_lvl  = LEVEL_W'(rows[i].af_lvl);
         thresh.almost_empty_lvl = LEVEL_W'(rows[i].ae_lvl);
         if (rows[i].overlap) begin
            n_cycles = (rows[i].n_wr > rows[i].n_rd) ? rows[i].n_wr : rows[i].n_rd;
            for (int c = 0; c < n_cycles; c++) begin
               drive_cycle(c < rows[i].n_wr, c < rows[i].n_rd, 1'b0);
            end
         end else begin
            repeat (rows[i].n_wr) drive_cycle(1'b1, 1'b0, 1'b0);
            repeat (rows[i].n_rd) drive_cycle(1'b0, 1'b1, 1'b0);
         end
         drive_cycle(1'b0, 1'b0, rows[i].clr);
         drive_cycle(1'b0, 1'b0, 1'b0);
         drive_cycle(1'b0, 1'b0, 1'b0);
         check_level(LEVEL_W'(rows[i].exp_level), status.level);
      end

      $display("Summary: data errors %0d, status errors %0d, level errors %0d",
               data_errs, status_errs, level_errs);
      if (data_errs + status_errs + level_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- all.f
design/fifo_cfg_pkg.sv
design/fifo_status_pkg.sv
design/iob_ram_2p_asym.sv
design/iob_fifo_sync.sv
design/fifo_level_monitor.sv
design/fifo_sync_top.sv
dv/fifo_sync_properties.sv
dv/fifo_sync_tb.sv

//--- Makefile
TOP := fifo_sync_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Testbench failed" sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
